//--- vlog.f
logic/dcache_pkg.sv
logic/cache_array.sv
logic/miss_queue.sv
logic/dcache.sv
verification/mem_model.sv
verification/dcache_tb_asserts.sv
verification/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module dcache_tb \
  -Mdir obj_dir -o dcache_sim

# a failed assertion stops the run, so the log decides
./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi

//--- verification/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
();

  localparam int NUM_SETS    = 32;
  localparam int MAX_CYCLES  = 4000;
  localparam int FILL_LIMIT  = 80;
  localparam addr_t SET_STRIDE = addr_t'(NUM_SETS * 8);

  logic         clock;
  logic         reset;
  logic         rd_en;
  addr_t        rd_addr;
  logic         wr_en;
  addr_t        wr_addr;
  word_t        wr_data;
  logic [4:0]   mem_random;
  mem_tag_t     mem_response;
  mem_tag_t     mem_tag;
  word_t        mem_data;
  logic         rd_valid;
  word_t        rd_data;
  addr_t        rd_miss_addr;
  word_t        rd_miss_data;
  logic         rd_miss_valid;
  bus_command_t mem_command;
  addr_t        mem_addr;

  logic [15:0] stim_lfsr;
  logic [15:0] mem_lfsr;
  int          cycle;
  int          value_errors;
  int          other_errors;

  // expected word per aligned address, and reads still waiting for a fill
  word_t ref_word [addr_t];
  bit    pending  [addr_t];

  dcache dcache_inst (.*);

  mem_model memory (
    .clock (clock), .reset (reset), .mem_command (mem_command), .mem_addr (mem_addr),
    .random (mem_random), .mem_response (mem_response), .mem_tag (mem_tag),
    .mem_data (mem_data)
  );

  always #2 clock = ~clock;

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] stim_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = galois_step(stim_lfsr);
      r = {r[30:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  function automatic addr_t aligned(input addr_t a);
    return {a[63:3], 3'b000};
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (expected === actual) else begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("failure: %s", what);
      other_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // free-running parts
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin : bus_random
    logic [4:0] bits;
    bits = '0;
    for (int i = 0; i < 5; i++) begin
      mem_lfsr = galois_step(mem_lfsr);
      bits = {bits[3:0], mem_lfsr[0]};
    end
    mem_random <= bits;
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // scoreboard on the falling edge, where all outputs are settled
  always @(negedge clock) begin : scoreboard
    addr_t a;
    if (!reset) begin
      if (rd_miss_valid) begin
        check_value("miss_align", 64'd0, 64'(rd_miss_addr[2:0]));
        check_value("miss_data", ~rd_miss_addr, rd_miss_data);
        check_true(pending.exists(rd_miss_addr), "miss pulse for an address with no pending read");
        pending.delete(rd_miss_addr);
        ref_word[rd_miss_addr] = ~rd_miss_addr;
      end
      if (rd_en) begin
        a = aligned(rd_addr);
        if (rd_valid) begin
          check_true(ref_word.exists(a), "hit on a word never loaded or written");
          if (ref_word.exists(a)) begin
            check_value("hit_data", ref_word[a], rd_data);
          end
        end else begin
          pending[a] = 1'b1;
        end
      end
      if (wr_en) begin
        a = aligned(wr_addr);
        ref_word[a] = wr_data;
        pending.delete(a);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // operations, one per cycle
  ////////////////////////////////////////////////////////////////////////

  task automatic drive_idle();
    @(posedge clock);
    rd_en <= 1'b0;
    wr_en <= 1'b0;
  endtask

  task automatic read_word(input addr_t a);
    @(posedge clock);
    rd_en   <= 1'b1;
    rd_addr <= a;
    wr_en   <= 1'b0;
  endtask

  task automatic write_word(input addr_t a, input word_t d);
    @(posedge clock);
    rd_en   <= 1'b0;
    wr_en   <= 1'b1;
    wr_addr <= a;
    wr_data <= d;
  endtask

  task automatic read_expect_hit(input string name, input addr_t a, input word_t d);
    read_word(a);
    @(negedge clock);
    check_value({name, "_valid"}, 64'd1, 64'(rd_valid));
    check_value({name, "_data"}, d, rd_data);
  endtask

  // pending is settled by the scoreboard before the next rising edge
  task automatic wait_fill(input addr_t a);
    int n;
    n = 0;
    do begin
      drive_idle();
      n++;
    end while (pending.exists(a) && n < FILL_LIMIT);
    check_true(!pending.exists(a), $sformatf("no miss pulse for address %h", a));
  endtask

  task automatic wait_memory_idle();
    int n;
    n = 0;
    do begin
      drive_idle();
      @(negedge clock);
      n++;
    end while ((memory.outstanding != 0 || mem_command != BUS_NONE) && n < FILL_LIMIT);
    check_true(memory.outstanding == 0, "memory still busy");
    // head entry pops one cycle after its answer
    drive_idle();
    drive_idle();
  endtask

  ////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    addr_t       a;
    addr_t       b;
    logic [31:0] op;
    word_t       d;
    clock = 1'b0;
    reset = 1'b1;
    rd_en = 1'b0;
    rd_addr = '0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    mem_random = '0;
    stim_lfsr = 16'd86;
    mem_lfsr = 16'd86;
    cycle = 0;
    value_errors = 0;
    other_errors = 0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // quiet after reset
    repeat (4) begin
      drive_idle();
      @(negedge clock);
      check_value("reset_rd_valid", 64'd0, 64'(rd_valid));
      check_value("reset_miss_valid", 64'd0, 64'(rd_miss_valid));
      check_value("reset_mem_command", 64'(BUS_NONE), 64'(mem_command));
    end

    // miss, fill, then hit with an unaligned byte address
    a = 64'h1008;
    read_word(a + 64'd3);
    wait_fill(a);
    read_expect_hit("miss_then_hit", a + 64'd3, ~a);

    // write then read
    write_word(64'h2010, 64'hdead_beef_0123_4567);
    read_expect_hit("write_then_read", 64'h2010, 64'hdead_beef_0123_4567);

    // store overtakes a pending load
    a = 64'h3018;
    read_word(a);
    write_word(a, 64'h0bad_cafe_f00d_1234);
    wait_memory_idle();
    check_value("stale_loads", 64'd1, 64'(memory.load_count[a]));
    read_expect_hit("stale_read", a, 64'h0bad_cafe_f00d_1234);

    // repeated reads, single load
    a = 64'h4020;
    repeat (3) read_word(a);
    wait_fill(a);
    check_value("repeat_loads", 64'd1, 64'(memory.load_count[a]));

    // two addresses on one index
    a = 64'h5028;
    b = a + SET_STRIDE;
    read_word(a);
    wait_fill(a);
    read_word(b);
    wait_fill(b);
    read_word(a);
    @(negedge clock);
    check_value("evict_rd_valid", 64'd0, 64'(rd_valid));
    wait_fill(a);
    read_expect_hit("refill", a, ~a);

    // burst of misses in flight together
    read_word(64'h7000);
    read_word(64'h7108);
    read_word(64'h7210);
    wait_fill(64'h7000);
    wait_fill(64'h7108);
    wait_fill(64'h7210);

    // random reads and writes over a small conflicting pool
    repeat (150) begin
      op = stim_bits(2);
      a = 64'h6000 + addr_t'(stim_bits(4)) * 64'd8;
      if (stim_bits(1) == 32'd1) begin
        a = a + SET_STRIDE;
      end
      if (op == 32'd0) begin
        d = {16'(stim_bits(16)), 16'(stim_bits(16)), 16'(stim_bits(16)), 16'(stim_bits(16))};
        write_word(a, d);
      end else begin
        read_word(a);
        @(negedge clock);
        if (!rd_valid) begin
          wait_fill(a);
        end
      end
    end

    wait_memory_idle();
    check_true(pending.size() == 0, "reads left without a miss pulse");
    check_true(memory.refusals > 0, "memory never refused a load");

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/dcache_tb_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb_asserts
  import dcache_pkg::*;
(
  input wire logic         clock,
  input wire logic         reset,
  input wire bus_command_t mem_command,
  input wire addr_t        mem_addr,
  input wire logic         rd_miss_valid
);

  // the cache never writes back
  no_store: assert property (
    @(posedge clock) disable iff (reset) mem_command != BUS_STORE
  ) else $error("store command on the memory bus");

  // loads are whole words
  load_aligned: assert property (
    @(posedge clock) disable iff (reset)
    mem_command == BUS_LOAD |-> mem_addr[WORD_OFFSET_BITS-1:0] == '0
  ) else $error("load address not word aligned");

  // quiet while in reset and on the first cycle after it
  reset_quiet: assert property (
    @(posedge clock) reset |=> !rd_miss_valid && mem_command == BUS_NONE
  ) else $error("miss pulse or bus command during or just after reset");

endmodule

bind dcache dcache_tb_asserts asserts_inst (
  .clock         (clock),
  .reset         (reset),
  .mem_command   (mem_command),
  .mem_addr      (mem_addr),
  .rd_miss_valid (rd_miss_valid)
);

`default_nettype wire

//--- verification/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model
  import dcache_pkg::*;
(
  input  wire logic         clock,
  input  wire logic         reset,
  input  wire bus_command_t mem_command,
  input  wire addr_t        mem_addr,
  // bits 1:0 refuse the load when zero, bits 4:2 pick the delay
  input  wire logic [4:0]   random,
  output mem_tag_t          mem_response,
  output mem_tag_t          mem_tag,
  output word_t             mem_data
);

  mem_tag_t next_tag;
  int       cycle;
  int       last_due;
  int       outstanding;
  int       refusals;
  int       load_count [addr_t];

  // accepted loads waiting for their answer, oldest first
  mem_tag_t ret_tag  [$];
  addr_t    ret_addr [$];
  int       ret_due  [$];

  assign mem_response = (mem_command == BUS_LOAD && random[1:0] != 2'b00) ? next_tag : '0;

  always @(posedge clock) begin : answer
    int due;
    if (reset) begin
      next_tag <= 4'd1;
      cycle    <= 0;
      mem_tag  <= '0;
      mem_data <= '0;
      last_due = 0;
      refusals = 0;
      ret_tag.delete();
      ret_addr.delete();
      ret_due.delete();
    end else begin
      cycle   <= cycle + 1;
      mem_tag <= '0;
      if (ret_tag.size() > 0 && ret_due[0] <= cycle) begin
        mem_tag  <= ret_tag.pop_front();
        mem_data <= ~ret_addr.pop_front();
        void'(ret_due.pop_front());
      end
      if (mem_command == BUS_LOAD && mem_response == '0) begin
        refusals = refusals + 1;
      end
      if (mem_response != '0) begin
        // answers stay in order even with a shorter delay
        due = cycle + 2 + int'(random[4:2]) % 7;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        ret_tag.push_back(mem_response);
        ret_addr.push_back(mem_addr);
        ret_due.push_back(due);
        load_count[mem_addr] = load_count[mem_addr] + 1;
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
    end
    outstanding = ret_tag.size();
  end

endmodule

`default_nettype wire

//--- logic/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache
  import dcache_pkg::*;
#(
  parameter int NUM_SETS        = 32,
  parameter int MEM_BUFFER_SIZE = 4
) (
  input  wire logic         clock,
  input  wire logic         reset,

  // processor read port
  input  wire logic         rd_en,
  input  wire addr_t        rd_addr,

  // processor write port
  input  wire logic         wr_en,
  input  wire addr_t        wr_addr,
  input  wire word_t        wr_data,

  // answers from main memory
  input  wire mem_tag_t     mem_response,
  input  wire mem_tag_t     mem_tag,
  input  wire word_t        mem_data,

  // hit data, same cycle as rd_en
  output logic              rd_valid,
  output word_t             rd_data,

  // miss data, some cycles later
  output addr_t             rd_miss_addr,
  output word_t             rd_miss_data,
  output logic              rd_miss_valid,

  // requests to main memory
  output bus_command_t      mem_command,
  output addr_t             mem_addr
);

  logic        rd_miss;
  cache_fill_t fill;

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  cache_array #(
    .NUM_SETS (NUM_SETS)
  ) array_inst (
    .clock    (clock),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .fill     (fill),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .rd_miss  (rd_miss)
  );

  //////////////////////////////////////////////////////////////////////
  // miss handling
  //////////////////////////////////////////////////////////////////////

  miss_queue #(
    .MEM_BUFFER_SIZE (MEM_BUFFER_SIZE)
  ) queue_inst (
    .clock         (clock),
    .reset         (reset),
    .rd_miss       (rd_miss),
    .rd_addr       (rd_addr),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .mem_response  (mem_response),
    .mem_tag       (mem_tag),
    .mem_data      (mem_data),
    .fill          (fill),
    .rd_miss_addr  (rd_miss_addr),
    .rd_miss_data  (rd_miss_data),
    .rd_miss_valid (rd_miss_valid),
    .mem_command   (mem_command),
    .mem_addr      (mem_addr)
  );

endmodule

`default_nettype wire

//--- logic/miss_queue.sv
`timescale 1ns/100ps
`default_nettype none

module miss_queue
  import dcache_pkg::*;
#(
  parameter int MEM_BUFFER_SIZE = 4
) (
  input  wire logic      clock,
  input  wire logic      reset,

  // read miss from the array
  input  wire logic      rd_miss,
  input  wire addr_t     rd_addr,

  // processor stores, to spot stale loads
  input  wire logic      wr_en,
  input  wire addr_t     wr_addr,

  // main memory answers
  input  wire mem_tag_t  mem_response,
  input  wire mem_tag_t  mem_tag,
  input  wire word_t     mem_data,

  output cache_fill_t    fill,

  output addr_t          rd_miss_addr,
  output word_t          rd_miss_data,
  output logic           rd_miss_valid,

  output bus_command_t   mem_command,
  output addr_t          mem_addr
);

  localparam int PTR_BITS = $clog2(MEM_BUFFER_SIZE);

  typedef logic [PTR_BITS-1:0] slot_t;
  typedef logic [PTR_BITS:0]   count_t;

  localparam count_t QUEUE_DEPTH = count_t'(MEM_BUFFER_SIZE);

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////

  // oldest entry at slot 0, entries shift down on pop
  mem_req_t [MEM_BUFFER_SIZE-1:0] queue;
  mem_req_t [MEM_BUFFER_SIZE-1:0] queue_next;

  // tail counts entries, send_ptr the sent ones, wait_ptr the answered ones
  count_t tail;
  count_t tail_next;
  count_t send_ptr;
  count_t send_ptr_next;
  count_t wait_ptr;
  count_t wait_ptr_next;

  logic send_request;
  logic send_request_next;

  // memory answer held for one cycle
  logic  fill_valid;
  addr_t fill_addr;
  word_t fill_data;

  addr_t                rd_line_addr;
  addr_t                wr_line_addr;
  logic [MEM_BUFFER_SIZE-1:0] rd_match;
  logic [MEM_BUFFER_SIZE-1:0] wr_match;
  slot_t                send_slot;
  slot_t                wait_slot;
  logic                 accepted;
  logic                 mem_done;
  logic                 done_fill;

  // clear the byte offset
  function automatic addr_t word_align(input addr_t addr);
    return {addr[$bits(addr_t)-1:WORD_OFFSET_BITS], {WORD_OFFSET_BITS{1'b0}}};
  endfunction

  assign rd_line_addr = word_align(rd_addr);
  assign wr_line_addr = word_align(wr_addr);

  //////////////////////////////////////////////////////////////////////
  // address search
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < MEM_BUFFER_SIZE; i++) begin
      rd_match[i] = queue[i].valid && (queue[i].address == rd_line_addr);
      wr_match[i] = wr_en && queue[i].valid && (queue[i].address == wr_line_addr);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory bus
  //////////////////////////////////////////////////////////////////////

  assign send_slot = send_ptr[PTR_BITS-1:0];
  assign wait_slot = wait_ptr[PTR_BITS-1:0];

  assign mem_command = send_request ? BUS_LOAD : BUS_NONE;
  assign mem_addr    = send_request ? queue[send_slot].address : '0;

  // nonzero response means the load took this tag
  assign accepted = send_request && (mem_response != '0);

  // answers come back in order, so only the oldest sent entry can match
  assign mem_done = (wait_ptr < send_ptr) && (mem_tag != '0) &&
                    (queue[wait_slot].mem_tag == mem_tag);

  // a store in the same cycle also makes the answer stale
  assign done_fill = queue[wait_slot].fill && !wr_match[wait_slot];

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    queue_next    = queue;
    tail_next     = tail;
    send_ptr_next = send_ptr;
    wait_ptr_next = wait_ptr;

    // stale loads still complete but no longer fill
    for (int i = 0; i < MEM_BUFFER_SIZE; i++) begin
      if (wr_match[i]) begin
        queue_next[i].fill = 1'b0;
      end
    end

    if (mem_done) begin
      queue_next[wait_slot].done = 1'b1;
      wait_ptr_next = wait_ptr_next + 1'b1;
    end

    // refused loads keep send_ptr and go out again
    if (accepted) begin
      queue_next[send_slot].mem_tag = mem_response;
      send_ptr_next = send_ptr_next + 1'b1;
    end

    // pop the head one cycle after it completed
    if (queue[0].done) begin
      for (int i = 0; i < MEM_BUFFER_SIZE - 1; i++) begin
        queue_next[i] = queue_next[i + 1];
      end
      queue_next[MEM_BUFFER_SIZE - 1] = '0;
      tail_next = tail_next - 1'b1;
      if (send_ptr_next != '0) begin
        send_ptr_next = send_ptr_next - 1'b1;
      end
      if (wait_ptr_next != '0) begin
        wait_ptr_next = wait_ptr_next - 1'b1;
      end
    end

    // new miss, dropped when the queue is full
    if (rd_miss && !(|rd_match) && (tail_next < QUEUE_DEPTH)) begin
      queue_next[tail_next[PTR_BITS-1:0]] = '{
        valid:   1'b1,
        address: rd_line_addr,
        mem_tag: '0,
        done:    1'b0,
        fill:    1'b1
      };
      tail_next = tail_next + 1'b1;
    end

    send_request_next = (send_ptr_next < tail_next);
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      queue        <= '0;
      tail         <= '0;
      send_ptr     <= '0;
      wait_ptr     <= '0;
      send_request <= 1'b0;
      fill_valid   <= 1'b0;
    end else begin
      queue        <= queue_next;
      tail         <= tail_next;
      send_ptr     <= send_ptr_next;
      wait_ptr     <= wait_ptr_next;
      send_request <= send_request_next;
      fill_valid   <= mem_done && done_fill;
    end
  end

  // capture of the matched answer
  always_ff @(posedge clock) begin
    if (mem_done) begin
      fill_addr <= queue[wait_slot].address;
      fill_data <= mem_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  // the fill and the miss pulse are the same event
  assign fill = '{valid: fill_valid, address: fill_addr, data: fill_data};

  assign rd_miss_valid = fill_valid;
  assign rd_miss_addr  = fill_addr;
  assign rd_miss_data  = fill_data;

endmodule

`default_nettype wire

//--- logic/cache_array.sv
`timescale 1ns/100ps
`default_nettype none

module cache_array
  import dcache_pkg::*;
#(
  parameter int NUM_SETS = 32
) (
  input  wire logic        clock,
  input  wire logic        reset,

  input  wire logic        rd_en,
  input  wire addr_t       rd_addr,

  input  wire logic        wr_en,
  input  wire addr_t       wr_addr,
  input  wire word_t       wr_data,

  // clean line from the miss queue
  input  wire cache_fill_t fill,

  output word_t            rd_data,
  output logic             rd_valid,
  output logic             rd_miss
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS   = LINE_ADDR_HIGH - WORD_OFFSET_BITS + 1 - INDEX_BITS;

  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [TAG_BITS-1:0]   tag_t;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  logic [NUM_SETS-1:0] line_valid;
  logic [NUM_SETS-1:0] line_dirty;
  tag_t                line_tag  [NUM_SETS];
  word_t               line_data [NUM_SETS];

  index_t rd_index;
  index_t wr_index;
  index_t fill_index;
  tag_t   rd_tag;
  tag_t   wr_tag;
  tag_t   fill_tag;
  logic   rd_hit;
  logic   fill_write;

  // index sits just above the word offset
  function automatic index_t addr_index(input addr_t addr);
    return addr[WORD_OFFSET_BITS +: INDEX_BITS];
  endfunction

  // tag is the rest up to LINE_ADDR_HIGH
  function automatic tag_t addr_tag(input addr_t addr);
    return addr[LINE_ADDR_HIGH -: TAG_BITS];
  endfunction

  assign rd_index   = addr_index(rd_addr);
  assign rd_tag     = addr_tag(rd_addr);
  assign wr_index   = addr_index(wr_addr);
  assign wr_tag     = addr_tag(wr_addr);
  assign fill_index = addr_index(fill.address);
  assign fill_tag   = addr_tag(fill.address);

  //////////////////////////////////////////////////////////////////////
  // read and hit compare
  //////////////////////////////////////////////////////////////////////

  assign rd_hit   = rd_en && line_valid[rd_index] && (line_tag[rd_index] == rd_tag);
  assign rd_valid = rd_hit;
  assign rd_miss  = rd_en && !rd_hit;
  assign rd_data  = line_data[rd_index];

  //////////////////////////////////////////////////////////////////////
  // writes
  //////////////////////////////////////////////////////////////////////

  // processor store wins over a fill to the same line
  assign fill_write = fill.valid && !(wr_en && (wr_index == fill_index));

  // line state
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
      line_dirty <= '0;
    end else begin
      if (fill_write) begin
        line_valid[fill_index] <= 1'b1;
        line_dirty[fill_index] <= 1'b0;
      end
      if (wr_en) begin
        line_valid[wr_index] <= 1'b1;
        line_dirty[wr_index] <= 1'b1;
      end
    end
  end

  // tag and data
  always_ff @(posedge clock) begin
    if (fill_write) begin
      line_tag[fill_index]  <= fill_tag;
      line_data[fill_index] <= fill.data;
    end
    if (wr_en) begin
      line_tag[wr_index]  <= wr_tag;
      line_data[wr_index] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  // byte address and data word of the 64-bit core
  typedef logic [63:0] addr_t;
  typedef logic [63:0] word_t;

  // memory transaction tag, zero means no tag or refused
  typedef logic [3:0] mem_tag_t;

  // byte offset inside one word
  localparam int WORD_OFFSET_BITS = 3;

  // highest address bit that takes part in index and tag
  localparam int LINE_ADDR_HIGH = 31;

  //////////////////////////////////////////////////////////////////////
  // memory bus
  //////////////////////////////////////////////////////////////////////

  // store is part of the bus encoding but never issued by the cache
  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_t;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////

  // fill write from the miss queue into the array
  typedef struct packed {
    logic  valid;
    addr_t address;
    word_t data;
  } cache_fill_t;

  // one outstanding load in the miss queue
  typedef struct packed {
    logic     valid;
    addr_t    address;
    mem_tag_t mem_tag;
    logic     done;
    // cleared when a store overtakes the load
    logic     fill;
  } mem_req_t;

endpackage

`default_nettype wire
